//--- include/xbar_ch_defines.svh
`ifndef XBAR_CH_DEFINES_SVH
`define XBAR_CH_DEFINES_SVH

// ---------------------------------------------------------------------
// channel request buffer geometry
// ---------------------------------------------------------------------
`define XBAR_CH_ENTRIES   5
`define XBAR_CH_BANKS     4

// ---------------------------------------------------------------------
// request fields
// ---------------------------------------------------------------------
// line address, byte offset within the line is dropped
`define XBAR_CH_ADDR_MSB  31
`define XBAR_CH_ADDR_LSB  4

// bank steering bits inside the line address
`define XBAR_CH_BANK_MSB  9
`define XBAR_CH_BANK_LSB  8

`define XBAR_CH_DATA_W    128   // one cache line of write data
`define XBAR_CH_OP_W      2

`endif

//--- hdl/xbar_ch_pkg.sv
`include "xbar_ch_defines.svh"

package xbar_ch_pkg;

  // entry index and pointers into the circular queue
  typedef logic [$clog2(`XBAR_CH_ENTRIES)-1:0] entry_idx_t;

  // one bit per queue entry
  typedef logic [`XBAR_CH_ENTRIES-1:0] entry_vec_t;

  // request payload
  typedef logic [`XBAR_CH_ADDR_MSB:`XBAR_CH_ADDR_LSB] line_addr_t;
  typedef logic [`XBAR_CH_DATA_W-1:0]                 line_data_t;
  typedef logic [`XBAR_CH_OP_W-1:0]                   req_op_t;

  // bank steering
  typedef logic [`XBAR_CH_BANK_MSB-`XBAR_CH_BANK_LSB:0] bank_id_t;
  typedef logic [`XBAR_CH_BANKS-1:0]                    bank_vec_t;

endpackage

//--- hdl/ch_buffer_ctrl.sv
`timescale 1ns/100ps

`include "xbar_ch_defines.svh"

module ch_buffer_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    req_valid_i,
  input  logic                    head_pending_i,
  output logic                    req_allow_in_o,
  output logic                    push_o,
  output xbar_ch_pkg::entry_idx_t wr_ptr_o,
  output xbar_ch_pkg::entry_idx_t rd_ptr_o
);

  import xbar_ch_pkg::*;

  entry_idx_t wr_ptr_q;
  entry_idx_t wr_ptr_nxt;
  entry_idx_t rd_ptr_q;
  entry_idx_t rd_ptr_nxt;
  logic [2:0] cnt_q;    // occupied entries, 0..5
  logic       pop;

  // ---------------------------------------------------------------------
  // accept / retire strobes
  // ---------------------------------------------------------------------
  assign req_allow_in_o = cnt_q < 3'(`XBAR_CH_ENTRIES);  // no same-cycle pop credit
  assign push_o         = req_valid_i & req_allow_in_o;

  // head entry already dispatched by its bank
  assign pop = (cnt_q != 3'd0) & ~head_pending_i;

  assign wr_ptr_nxt = (wr_ptr_q == entry_idx_t'(`XBAR_CH_ENTRIES - 1)) ? '0
                                                                       : wr_ptr_q + entry_idx_t'(1);
  assign rd_ptr_nxt = (rd_ptr_q == entry_idx_t'(`XBAR_CH_ENTRIES - 1)) ? '0
                                                                       : rd_ptr_q + entry_idx_t'(1);

  // ---------------------------------------------------------------------
  // pointers
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
    end else if (push_o) begin
      wr_ptr_q <= wr_ptr_nxt;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
    end else if (pop) begin
      rd_ptr_q <= rd_ptr_nxt;
    end
  end

  // ---------------------------------------------------------------------
  // occupancy
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= 3'd0;
    end else begin
      case ({push_o, pop})
        2'b10:   cnt_q <= cnt_q + 3'd1;
        2'b01:   cnt_q <= cnt_q - 3'd1;
        default: cnt_q <= cnt_q;    // both or neither
      endcase
    end
  end

  assign wr_ptr_o = wr_ptr_q;
  assign rd_ptr_o = rd_ptr_q;

endmodule

//--- hdl/ch_bank_valid_array.sv
`timescale 1ns/100ps

`include "xbar_ch_defines.svh"

module ch_bank_valid_array (
  input  logic                                            clk_i,
  input  logic                                            rst_i,
  input  logic                                            push_i,
  input  xbar_ch_pkg::bank_id_t                           req_bank_i,
  input  xbar_ch_pkg::entry_idx_t                         wr_ptr_i,
  input  xbar_ch_pkg::entry_idx_t                         rd_ptr_i,
  input  xbar_ch_pkg::entry_idx_t [`XBAR_CH_BANKS-1:0]    pick_idx_i,
  input  xbar_ch_pkg::bank_vec_t                          bank_grant_i,
  input  xbar_ch_pkg::bank_vec_t                          bank_can_go_i,
  output xbar_ch_pkg::entry_vec_t [`XBAR_CH_BANKS-1:0]    bank_valid_o,
  output xbar_ch_pkg::bank_vec_t                          bank_want_o,
  output logic                                            head_pending_o
);

  import xbar_ch_pkg::*;

  entry_vec_t                      wr_dcd;
  entry_vec_t                      rd_dcd;
  entry_vec_t [`XBAR_CH_BANKS-1:0] set_vec;
  entry_vec_t [`XBAR_CH_BANKS-1:0] clr_vec;
  entry_vec_t [`XBAR_CH_BANKS-1:0] valid_d;
  entry_vec_t [`XBAR_CH_BANKS-1:0] valid_q;
  bank_vec_t                       dispatch;
  bank_vec_t                       head_hit;

  assign wr_dcd   = entry_vec_t'(1) << wr_ptr_i;
  assign rd_dcd   = entry_vec_t'(1) << rd_ptr_i;
  assign dispatch = bank_grant_i & bank_can_go_i;

  // ---------------------------------------------------------------------
  // set on push, clear on dispatch
  // ---------------------------------------------------------------------
  always_comb begin
    for (int b = 0; b < `XBAR_CH_BANKS; b++) begin
      set_vec[b] = (push_i && req_bank_i == bank_id_t'(b)) ? wr_dcd : '0;
      clr_vec[b] = dispatch[b] ? (entry_vec_t'(1) << pick_idx_i[b]) : '0;
      valid_d[b] = (valid_q[b] & ~clr_vec[b]) | set_vec[b];
      bank_want_o[b] = |valid_q[b];
      head_hit[b]    = |(valid_q[b] & rd_dcd);   // bank still owns the head
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // head can only retire once no bank holds it
  assign head_pending_o = |head_hit;
  assign bank_valid_o   = valid_q;

endmodule

//--- hdl/ch_oldest_entry_pick.sv
`timescale 1ns/100ps

`include "xbar_ch_defines.svh"

module ch_oldest_entry_pick (
  input  xbar_ch_pkg::entry_vec_t bank_valid_i,
  input  xbar_ch_pkg::entry_idx_t rd_ptr_i,
  output xbar_ch_pkg::entry_idx_t pick_idx_o
);

  import xbar_ch_pkg::*;

  logic [3:0] scan_sum;   // one bit wider than a pointer
  entry_idx_t scan_idx;
  entry_idx_t pick;
  logic       found;

  // ---------------------------------------------------------------------
  // scan upward from the read pointer, wrapping after the last entry;
  // the first hit is the oldest entry of this bank
  // ---------------------------------------------------------------------
  always_comb begin
    pick     = rd_ptr_i;   // falls back to head when bank is empty
    found    = 1'b0;
    scan_sum = '0;
    scan_idx = '0;
    for (int k = 0; k < `XBAR_CH_ENTRIES; k++) begin
      scan_sum = {1'b0, rd_ptr_i} + 4'(k);
      if (scan_sum >= 4'(`XBAR_CH_ENTRIES)) begin
        scan_sum = scan_sum - 4'(`XBAR_CH_ENTRIES);
      end
      scan_idx = entry_idx_t'(scan_sum);
      if (!found && bank_valid_i[scan_idx]) begin
        pick  = scan_idx;
        found = 1'b1;
      end
    end
  end

  assign pick_idx_o = pick;

endmodule

//--- hdl/ch_entry_store.sv
`timescale 1ns/100ps

`include "xbar_ch_defines.svh"

module ch_entry_store (
  input  logic                                         clk_i,
  input  logic                                         push_i,
  input  xbar_ch_pkg::entry_idx_t                      wr_ptr_i,
  input  xbar_ch_pkg::req_op_t                         req_op_i,
  input  xbar_ch_pkg::line_addr_t                      req_addr_i,
  input  xbar_ch_pkg::line_data_t                      req_data_i,
  input  xbar_ch_pkg::entry_idx_t [`XBAR_CH_BANKS-1:0] pick_idx_i,
  output xbar_ch_pkg::req_op_t    [`XBAR_CH_BANKS-1:0] bank_op_o,
  output xbar_ch_pkg::line_addr_t [`XBAR_CH_BANKS-1:0] bank_addr_o,
  output xbar_ch_pkg::line_data_t [`XBAR_CH_BANKS-1:0] bank_data_o
);

  import xbar_ch_pkg::*;

  req_op_t    op_mem   [`XBAR_CH_ENTRIES];
  line_addr_t addr_mem [`XBAR_CH_ENTRIES];
  line_data_t data_mem [`XBAR_CH_ENTRIES];

  // ---------------------------------------------------------------------
  // entry write at the accept edge
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      op_mem[wr_ptr_i]   <= req_op_i;
      addr_mem[wr_ptr_i] <= req_addr_i;
      data_mem[wr_ptr_i] <= req_data_i;
    end
  end

  // ---------------------------------------------------------------------
  // per-bank read mux
  // ---------------------------------------------------------------------
  always_comb begin
    for (int b = 0; b < `XBAR_CH_BANKS; b++) begin
      bank_op_o[b]   = '0;   // zero for an unused index
      bank_addr_o[b] = '0;
      bank_data_o[b] = '0;
      for (int e = 0; e < `XBAR_CH_ENTRIES; e++) begin
        if (pick_idx_i[b] == entry_idx_t'(e)) begin
          bank_op_o[b]   = op_mem[e];
          bank_addr_o[b] = addr_mem[e];
          bank_data_o[b] = data_mem[e];
        end
      end
    end
  end

endmodule

//--- hdl/ch_req_buffer_top.sv
`timescale 1ns/100ps

`include "xbar_ch_defines.svh"

module ch_req_buffer_top (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  // request side
  input  logic                                         req_valid_i,
  output logic                                         req_allow_in_o,
  input  xbar_ch_pkg::req_op_t                         req_op_i,
  input  xbar_ch_pkg::line_addr_t                      req_addr_i,
  input  xbar_ch_pkg::line_data_t                      req_data_i,
  // bank side
  output xbar_ch_pkg::bank_vec_t                       bank_want_o,
  input  xbar_ch_pkg::bank_vec_t                       bank_grant_i,
  input  xbar_ch_pkg::bank_vec_t                       bank_can_go_i,
  output xbar_ch_pkg::req_op_t    [`XBAR_CH_BANKS-1:0] bank_op_o,
  output xbar_ch_pkg::line_addr_t [`XBAR_CH_BANKS-1:0] bank_addr_o,
  output xbar_ch_pkg::line_data_t [`XBAR_CH_BANKS-1:0] bank_data_o
);

  import xbar_ch_pkg::*;

  logic                            push;
  logic                            head_pending;
  entry_idx_t                      wr_ptr;
  entry_idx_t                      rd_ptr;
  entry_vec_t [`XBAR_CH_BANKS-1:0] bank_valid;
  entry_idx_t [`XBAR_CH_BANKS-1:0] pick_idx;

  // ---------------------------------------------------------------------
  // queue control
  // ---------------------------------------------------------------------
  ch_buffer_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_valid_i    (req_valid_i),
    .head_pending_i (head_pending),
    .req_allow_in_o (req_allow_in_o),
    .push_o         (push),
    .wr_ptr_o       (wr_ptr),
    .rd_ptr_o       (rd_ptr)
  );

  ch_bank_valid_array u_valid (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .push_i         (push),
    .req_bank_i     (req_addr_i[`XBAR_CH_BANK_MSB:`XBAR_CH_BANK_LSB]),  // steering bits
    .wr_ptr_i       (wr_ptr),
    .rd_ptr_i       (rd_ptr),
    .pick_idx_i     (pick_idx),
    .bank_grant_i   (bank_grant_i),
    .bank_can_go_i  (bank_can_go_i),
    .bank_valid_o   (bank_valid),
    .bank_want_o    (bank_want_o),
    .head_pending_o (head_pending)
  );

  // ---------------------------------------------------------------------
  // oldest-entry pick, one per bank
  // ---------------------------------------------------------------------
  for (genvar g = 0; g < `XBAR_CH_BANKS; g++) begin : g_pick
    ch_oldest_entry_pick u_pick (
      .bank_valid_i (bank_valid[g]),
      .rd_ptr_i     (rd_ptr),
      .pick_idx_o   (pick_idx[g])
    );
  end

  ch_entry_store u_store (
    .clk_i       (clk_i),
    .push_i      (push),
    .wr_ptr_i    (wr_ptr),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_data_i  (req_data_i),
    .pick_idx_i  (pick_idx),
    .bank_op_o   (bank_op_o),
    .bank_addr_o (bank_addr_o),
    .bank_data_o (bank_data_o)
  );

endmodule

//--- tb/tb_ch_req_buffer.sv
`timescale 1ns/100ps

`include "xbar_ch_defines.svh"

module tb_ch_req_buffer;

  import xbar_ch_pkg::*;

  localparam int MAX_CYCLES = 3000;

  logic                            clk_i;
  logic                            rst_i;
  logic                            req_valid_i;
  logic                            req_allow_in_o;
  req_op_t                         req_op_i;
  line_addr_t                      req_addr_i;
  line_data_t                      req_data_i;
  bank_vec_t                       bank_want_o;
  bank_vec_t                       bank_grant_i;
  bank_vec_t                       bank_can_go_i;
  req_op_t    [`XBAR_CH_BANKS-1:0] bank_op_o;
  line_addr_t [`XBAR_CH_BANKS-1:0] bank_addr_o;
  line_data_t [`XBAR_CH_BANKS-1:0] bank_data_o;

  // reference model of every accepted request in accept order
  bank_id_t   gq_bank [$];
  logic       gq_done [$];   // dispatched but not yet retired
  req_op_t    gq_op   [$];
  line_addr_t gq_addr [$];
  line_data_t gq_data [$];

  int cycle_cnt;
  int err_count;
  int errs_at_start;
  int tests_run;
  int tests_failed;
  int dispatch_cnt;

  ch_req_buffer_top dut0 (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_valid_i    (req_valid_i),
    .req_allow_in_o (req_allow_in_o),
    .req_op_i       (req_op_i),
    .req_addr_i     (req_addr_i),
    .req_data_i     (req_data_i),
    .bank_want_o    (bank_want_o),
    .bank_grant_i   (bank_grant_i),
    .bank_can_go_i  (bank_can_go_i),
    .bank_op_o      (bank_op_o),
    .bank_addr_o    (bank_addr_o),
    .bank_data_o    (bank_data_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycle_cnt);
      $display("TEST FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // model helpers
  // ----------------------------------------------------------------------
  // oldest entry of a bank that is still waiting for dispatch
  function automatic int find_front(input int b);
    int idx;
    idx = -1;
    for (int i = gq_bank.size() - 1; i >= 0; i--) begin
      if (gq_bank[i] == bank_id_t'(b) && !gq_done[i]) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  function automatic line_addr_t make_addr(input int b, input logic [31:0] tag);
    line_addr_t a;
    a = line_addr_t'(tag);
    a[`XBAR_CH_BANK_MSB:`XBAR_CH_BANK_LSB] = bank_id_t'(b);  // steering bits
    return a;
  endfunction

  task automatic report_mismatch(input string name, input string what,
                                 input logic [127:0] exp_v, input logic [127:0] act_v);
    $display("mismatch %s %s: expected %0h actual %0h", name, what, exp_v, act_v);
    err_count++;
  endtask

  task automatic report_failure(input string name, input string text);
    $display("%s: %s", name, text);
    err_count++;
  endtask

  task automatic check_outputs(input string name);
    int idx;
    for (int b = 0; b < `XBAR_CH_BANKS; b++) begin
      idx = find_front(b);
      if (idx < 0) begin
        if (bank_want_o[b] !== 1'b0) begin
          report_failure(name, $sformatf("bank %0d wants with nothing pending", b));
        end
      end else if (bank_want_o[b] !== 1'b1) begin
        report_failure(name, $sformatf("bank %0d does not want its pending entry", b));
      end else begin
        if (bank_op_o[b] !== gq_op[idx]) begin
          report_mismatch(name, $sformatf("bank %0d op", b), 128'(gq_op[idx]),
                          128'(bank_op_o[b]));
        end
        if (bank_addr_o[b] !== gq_addr[idx]) begin
          report_mismatch(name, $sformatf("bank %0d addr", b), 128'(gq_addr[idx]),
                          128'(bank_addr_o[b]));
        end
        if (bank_data_o[b] !== gq_data[idx]) begin
          report_mismatch(name, $sformatf("bank %0d data", b), gq_data[idx], bank_data_o[b]);
        end
      end
    end
    if (req_allow_in_o !== (gq_bank.size() < `XBAR_CH_ENTRIES)) begin
      report_mismatch(name, "allow-in", 128'(gq_bank.size() < `XBAR_CH_ENTRIES),
                      128'(req_allow_in_o));
    end
  endtask

  // ----------------------------------------------------------------------
  // drive one cycle and check at the falling edge before the model
  // steps to the coming rising edge
  // ----------------------------------------------------------------------
  task automatic apply_cycle(input string name, input logic valid, input req_op_t op,
                             input line_addr_t addr, input line_data_t data,
                             input bank_vec_t grant, input bank_vec_t can_go,
                             output logic accepted);
    logic pop;
    int   idx;
    @(posedge clk_i);
    req_valid_i   <= valid;
    req_op_i      <= op;
    req_addr_i    <= addr;
    req_data_i    <= data;
    bank_grant_i  <= grant;
    bank_can_go_i <= can_go;
    @(negedge clk_i);
    check_outputs(name);
    accepted = valid && (gq_bank.size() < `XBAR_CH_ENTRIES);
    pop = (gq_bank.size() != 0) && gq_done[0];   // head retires one edge after dispatch
    for (int b = 0; b < `XBAR_CH_BANKS; b++) begin
      if (grant[b] && can_go[b]) begin
        idx = find_front(b);
        if (idx >= 0) begin
          gq_done[idx] = 1'b1;
          dispatch_cnt++;
        end
      end
    end
    if (pop) begin
      void'(gq_bank.pop_front());
      void'(gq_done.pop_front());
      void'(gq_op.pop_front());
      void'(gq_addr.pop_front());
      void'(gq_data.pop_front());
    end
    if (accepted) begin
      gq_bank.push_back(addr[`XBAR_CH_BANK_MSB:`XBAR_CH_BANK_LSB]);
      gq_done.push_back(1'b0);
      gq_op.push_back(op);
      gq_addr.push_back(addr);
      gq_data.push_back(data);
    end
  endtask

  task automatic grant_cycle(input string name, input bank_vec_t grant, input bank_vec_t can_go);
    logic acc;
    apply_cycle(name, 1'b0, '0, '0, '0, grant, can_go, acc);
  endtask

  task automatic send_req(input string name, input req_op_t op, input line_addr_t addr,
                          input line_data_t data);
    logic acc;
    int   tries;
    acc   = 1'b0;
    tries = 0;
    while (!acc && tries < 20) begin
      apply_cycle(name, 1'b1, op, addr, data, '0, '0, acc);
      tries++;
    end
    if (!acc) begin
      report_failure(name, "request was never accepted");
    end
  endtask

  task automatic drain(input string name);
    int tries;
    tries = 0;
    while (gq_bank.size() != 0 && tries < 40) begin
      grant_cycle(name, '1, '1);
      tries++;
    end
    if (gq_bank.size() != 0) begin
      report_failure(name, "buffer did not drain with all grants high");
    end
  endtask

  task automatic start_test();
    errs_at_start = err_count;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (err_count == errs_at_start) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, err_count - errs_at_start);
    end
  endtask

  // ----------------------------------------------------------------------
  // tests
  // ----------------------------------------------------------------------
  task automatic test_reset_state();
    start_test();
    grant_cycle("reset_state", '0, '0);
    if (req_allow_in_o !== 1'b1) begin
      report_mismatch("reset_state", "allow-in", 128'(1), 128'(req_allow_in_o));
    end
    if (bank_want_o !== '0) begin
      report_mismatch("reset_state", "want", 128'(0), 128'(bank_want_o));
    end
    finish_test("reset_state");
  endtask

  task automatic test_routing();
    line_data_t d;
    start_test();
    for (int b = 0; b < `XBAR_CH_BANKS; b++) begin
      d = {4{32'hc0de_0000 + 32'(b)}};
      send_req("routing", req_op_t'(b), make_addr(b, 32'h0a5a_5000 + 32'(b)), d);
      grant_cycle("routing", '0, '0);
      if (bank_want_o !== bank_vec_t'(1) << b) begin
        report_mismatch("routing", "want", 128'(bank_vec_t'(1) << b), 128'(bank_want_o));
      end
      if (bank_data_o[b] !== d) begin
        report_mismatch("routing", "data", d, bank_data_o[b]);
      end
      grant_cycle("routing", bank_vec_t'(1) << b, bank_vec_t'(1) << b);
      grant_cycle("routing", '0, '0);
      if (bank_want_o !== '0) begin
        report_mismatch("routing", "want after dispatch", 128'(0), 128'(bank_want_o));
      end
    end
    finish_test("routing");
  endtask

  task automatic test_bank_order();
    line_data_t d [3];
    start_test();
    for (int i = 0; i < 3; i++) begin
      d[i] = {4{32'hb2b2_0000 + 32'(i)}};
      send_req("bank_order", req_op_t'(i), make_addr(2, 32'h0000_7000 + 32'(i)), d[i]);
    end
    send_req("bank_order", 2'd3, make_addr(0, 32'h0000_7100), {4{32'hb0b0_0003}});
    grant_cycle("bank_order", 4'b0001, 4'b0001);   // younger bank-0 entry goes first
    grant_cycle("bank_order", '0, '0);
    for (int i = 0; i < 3; i++) begin
      grant_cycle("bank_order", 4'b0100, 4'b0100);
      if (bank_data_o[2] !== d[i]) begin
        report_mismatch("bank_order", $sformatf("bank 2 entry %0d", i), d[i], bank_data_o[2]);
      end
    end
    drain("bank_order");
    finish_test("bank_order");
  endtask

  task automatic test_full_backpressure();
    int         bank_seq [5] = '{1, 3, 0, 2, 3};
    line_data_t d6;
    logic       acc;
    logic       allow_seen;
    int         edges;
    start_test();
    d6 = {4{32'hf00d_0006}};
    for (int i = 0; i < 5; i++) begin
      send_req("full", req_op_t'(i), make_addr(bank_seq[i], 32'h0000_9000 + 32'(i)),
               {4{32'hf00d_0000 + 32'(i)}});
    end
    for (int i = 0; i < 2; i++) begin
      apply_cycle("full", 1'b1, 2'd1, make_addr(0, 32'h0000_9006), d6, '0, '0, acc);
      if (acc || req_allow_in_o !== 1'b0) begin
        report_failure("full", "sixth request let in while buffer full");
      end
    end
    // dispatch the head which is the only bank 1 entry
    apply_cycle("full", 1'b1, 2'd1, make_addr(0, 32'h0000_9006), d6, 4'b0010, 4'b0010, acc);
    edges      = 0;
    allow_seen = 1'b0;
    while (!allow_seen && edges < 10) begin
      apply_cycle("full", 1'b1, 2'd1, make_addr(0, 32'h0000_9006), d6, '0, '0, acc);
      allow_seen = (req_allow_in_o === 1'b1);
      edges++;
    end
    if (!allow_seen) begin
      report_failure("full", "allow-in never rose after the head was dispatched");
    end else if (edges != 2) begin
      report_mismatch("full", "edges until allow-in rose", 128'(2), 128'(edges));
    end
    drain("full");
    finish_test("full");
  endtask

  task automatic test_can_go();
    int         bank_seq [5] = '{0, 1, 2, 3, 1};
    line_data_t d [5];
    start_test();
    for (int i = 0; i < 5; i++) begin
      d[i] = {4{32'hcafe_0000 + 32'(i)}};
      send_req("can_go", req_op_t'(i), make_addr(bank_seq[i], 32'h0000_b000 + 32'(i)), d[i]);
    end
    for (int i = 0; i < 3; i++) begin
      grant_cycle("can_go", 4'b0010, 4'b0000);
      if (bank_want_o[1] !== 1'b1 || bank_data_o[1] !== d[1]) begin
        report_failure("can_go", "bank 1 entry changed with can-go low");
      end
    end
    grant_cycle("can_go", 4'b0010, 4'b0010);
    for (int i = 0; i < 3; i++) begin
      grant_cycle("can_go", '0, '0);
      if (req_allow_in_o !== 1'b0) begin
        report_failure("can_go", "non-head dispatch freed room in a full buffer");
      end
      if (bank_data_o[1] !== d[4]) begin
        report_mismatch("can_go", "bank 1 next entry", d[4], bank_data_o[1]);
      end
    end
    drain("can_go");
    finish_test("can_go");
  endtask

  task automatic test_random_mix();
    logic acc;
    logic valid;
    int   outstanding;
    int   disp_before;
    start_test();
    disp_before = dispatch_cnt;
    for (int i = 0; i < 200; i++) begin
      valid       = 1'($urandom);
      outstanding = gq_bank.size();
      apply_cycle("random_mix", valid, req_op_t'($urandom),
                  make_addr(int'($urandom % 4), $urandom),
                  {$urandom, $urandom, $urandom, $urandom},
                  bank_vec_t'($urandom), bank_vec_t'($urandom), acc);
      if (valid && req_allow_in_o === 1'b1 && outstanding >= `XBAR_CH_ENTRIES) begin
        report_failure("random_mix", "request let in with five entries outstanding");
      end
    end
    if (dispatch_cnt == disp_before) begin
      report_failure("random_mix", "no entry was dispatched");
    end
    drain("random_mix");
    finish_test("random_mix");
  endtask

  initial begin
    rst_i         = 1'b1;
    req_valid_i   = 1'b0;
    req_op_i      = '0;
    req_addr_i    = '0;
    req_data_i    = '0;
    bank_grant_i  = '0;
    bank_can_go_i = '0;
    void'($urandom(32'hb43));
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;

    test_reset_state();
    test_routing();
    test_bank_order();
    test_full_backpressure();
    test_can_go();
    test_random_mix();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
hdl/xbar_ch_pkg.sv
hdl/ch_buffer_ctrl.sv
hdl/ch_bank_valid_array.sv
hdl/ch_oldest_entry_pick.sv
hdl/ch_entry_store.sv
hdl/ch_req_buffer_top.sv
tb/tb_ch_req_buffer.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_ch_req_buffer
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
